// ==== hw/ics_periph_pkg.sv ====
/*
 * Shared types and constants for the peripheral block:
 * host bus request, peripheral select and flash pin structs,
 * address region enum and register field positions
 */

package ics_periph_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [31:0] data_t;

    // Any strobe set means write, all clear means read
    typedef struct packed {
        addr_t      addr;
        data_t      wdata;
        logic [3:0] wstrb;
    } bus_req_t;

    // Address map
    localparam int REGION_LSB  = 16;
    localparam int REGION_BITS = 4;
    localparam int REG_SEL_BIT = 2;

    typedef enum logic [REGION_BITS-1:0] {
        STATUS     = 4'd0,
        DSP        = 4'd1,
        PAD        = 4'd2,
        FLASH_CTRL = 4'd3
    } region_e;

    // One cycle select from the decoder, unmapped requests get their own enable
    typedef struct packed {
        logic  status_en;
        logic  dsp_en;
        logic  pad_en;
        logic  flash_ctrl_en;
        logic  unmapped_en;
        logic  write;
        logic  reg_sel;
        data_t wdata;
    } periph_sel_t;

    typedef struct packed {
        logic [1:0] clk_ddr;
        logic       csn;
        logic [3:0] dout;
        logic [3:0] oe;
    } flash_pins_t;

    // Flash control word fields
    localparam int FC_IN_LSB     = 0;
    localparam int FC_OE_LSB     = 4;
    localparam int FC_CLK_BIT    = 8;
    localparam int FC_CSN_BIT    = 9;
    localparam int FC_ACTIVE_BIT = 15;

    // Pad control word fields
    localparam int PAD_LATCH_BIT = 0;
    localparam int PAD_CLK_BIT   = 1;

endpackage

// ==== hw/periph_decoder.sv ====
/*
 * Registered address decoder for the host bus.
 * Produces a single cycle peripheral select per request.
 */

`timescale 1ns/1ps

module periph_decoder import ics_periph_pkg::*; (
    input  logic        vdp_clk,
    input  logic        vdp_reset,
    input  bus_req_t    bus_req,
    input  logic        mem_valid,
    output periph_sel_t sel
);

    region_e    region;
    logic [4:0] hit;
    logic [4:0] en_q;
    logic       busy;
    logic       start;
    logic       write_q;
    logic       reg_sel_q;
    data_t      wdata_q;

    assign region = region_e'(bus_req.addr[REGION_LSB +: REGION_BITS]);

    // Only the first cycle of a held request fires
    assign start = mem_valid && !busy;

    always_comb begin
        hit = '0;
        case (region)
            STATUS:     hit[4] = 1'b1;
            DSP:        hit[3] = 1'b1;
            PAD:        hit[2] = 1'b1;
            FLASH_CTRL: hit[1] = 1'b1;
            default:    hit[0] = 1'b1;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            busy <= 1'b0;
            en_q <= '0;
        end else begin
            busy <= mem_valid;
            en_q <= start ? hit : '0;
        end
    end

    always_ff @(posedge vdp_clk) begin
        write_q   <= |bus_req.wstrb;
        reg_sel_q <= bus_req.addr[REG_SEL_BIT];
        wdata_q   <= bus_req.wdata;
    end

    always_comb begin
        sel.status_en     = en_q[4];
        sel.dsp_en        = en_q[3];
        sel.pad_en        = en_q[2];
        sel.flash_ctrl_en = en_q[1];
        sel.unmapped_en   = en_q[0];
        sel.write         = write_q;
        sel.reg_sel       = reg_sel_q;
        sel.wdata         = wdata_q;
    end

    // A held request selects its peripheral for a single cycle
    a_sel_single: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        |en_q |=> en_q == '0);

endmodule

// ==== hw/dsp_mult.sv ====
/*
 * Memory mapped signed multiplier.
 * Two operand registers and a registered product.
 */

`timescale 1ns/1ps

module dsp_mult import ics_periph_pkg::*; #(
    parameter int DSP_WIDTH = 16
) (
    input  logic        vdp_clk,
    input  periph_sel_t sel,
    output data_t       product
);

    logic signed [DSP_WIDTH-1:0] op_a;
    logic signed [DSP_WIDTH-1:0] op_b;
    logic                        write_a;
    logic                        write_b;

    // Register select bit picks the operand
    assign write_a = sel.dsp_en && sel.write && !sel.reg_sel;
    assign write_b = sel.dsp_en && sel.write && sel.reg_sel;

    // Operand loads kept flat so they land in the DSP input registers
    always_ff @(posedge vdp_clk) begin
        if (write_a) begin
            op_a <= sel.wdata[DSP_WIDTH-1:0];
        end

        if (write_b) begin
            op_b <= sel.wdata[DSP_WIDTH-1:0];
        end

        // Signed only, sign extended to the bus width
        product <= data_t'(op_a * op_b);
    end

endmodule

// ==== hw/pad_reader.sv ====
/*
 * Gamepad reader with a mocked serial pad built from board buttons,
 * plus the sampled user button
 */

`timescale 1ns/1ps

module pad_reader import ics_periph_pkg::*; (
    input  logic        vdp_clk,
    input  logic        vdp_reset,
    input  periph_sel_t sel,
    input  logic        btn_u,
    input  logic        btn_1,
    input  logic        btn_2,
    input  logic        btn_3,
    output logic [1:0]  pad_data
);

    logic        pad_latch;
    logic        pad_clk;
    logic        pad_clk_r;
    logic        clk_rise;
    logic [15:0] pad_state;
    logic        user_button_r;

    assign clk_rise = pad_clk && !pad_clk_r;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_latch <= 1'b0;
            pad_clk   <= 1'b0;
            pad_clk_r <= 1'b0;
        end else begin
            if (sel.pad_en && sel.write) begin
                pad_latch <= sel.wdata[PAD_LATCH_BIT];
                pad_clk   <= sel.wdata[PAD_CLK_BIT];
            end
            pad_clk_r <= pad_clk;
        end
    end

    // Mock shift register, B at bit 0, right at bit 6, left at bit 7
    always_ff @(posedge vdp_clk) begin
        if (pad_latch) begin
            pad_state <= {8'b0, btn_1, btn_3, 5'b0, btn_2};
        end

        if (clk_rise) begin
            pad_state <= {1'b0, pad_state[15:1]};
        end
    end

    // No debounce on the user button
    always_ff @(posedge vdp_clk) begin
        user_button_r <= btn_u;
    end

    // Bit 1 carries the user button in place of a second pad
    assign pad_data = {user_button_r, pad_state[0]};

endmodule

// ==== hw/flash_bitbang.sv ====
/*
 * CPU driven bit-bang control of the quad SPI flash pins.
 * Pins idle while the controller is inactive.
 */

`timescale 1ns/1ps

module flash_bitbang import ics_periph_pkg::*; (
    input  logic        vdp_clk,
    input  logic        vdp_reset,
    input  periph_sel_t sel,
    input  logic [3:0]  flash_out,
    output flash_pins_t flash,
    output data_t       ctrl_read
);

    logic       active;
    logic       fc_clk;
    logic       fc_csn;
    logic [3:0] fc_oe;
    logic [3:0] fc_dout;
    logic       ctrl_write;

    assign ctrl_write = sel.flash_ctrl_en && sel.write;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            active <= 1'b0;
            fc_clk <= 1'b0;
            fc_csn <= 1'b1;
            fc_oe  <= '0;
        end else if (ctrl_write) begin
            active <= sel.wdata[FC_ACTIVE_BIT];
            fc_clk <= sel.wdata[FC_CLK_BIT];
            fc_csn <= sel.wdata[FC_CSN_BIT];
            fc_oe  <= sel.wdata[FC_OE_LSB +: 4];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (ctrl_write) begin
            fc_dout <= sel.wdata[FC_IN_LSB +: 4];
        end
    end

    // Both DDR phases carry the same level in bit-bang mode
    always_comb begin
        flash.clk_ddr = active ? {2{fc_clk}} : 2'b00;
        flash.csn     = active ? fc_csn : 1'b1;
        flash.dout    = active ? fc_dout : 4'b0000;
        flash.oe      = active ? fc_oe : 4'b0000;
    end

    // flash_out is expected to be registered at the pad
    assign ctrl_read = data_t'(flash_out);

    // Clearing active releases the bus on the next cycle
    a_idle_after_release: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        ctrl_write && !sel.wdata[FC_ACTIVE_BIT] |=> flash.oe == 4'b0000 && flash.csn);

endmodule

// ==== hw/periph_read_mux.sv ====
/*
 * Read-back multiplexer, registers the read word and the ready pulse
 */

`timescale 1ns/1ps

module periph_read_mux import ics_periph_pkg::*; (
    input  logic        vdp_clk,
    input  logic        vdp_reset,
    input  periph_sel_t sel,
    input  data_t       dsp_data,
    input  data_t       flash_data,
    input  logic [1:0]  pad_data,
    output logic        mem_ready,
    output data_t       read_data
);

    logic  any_en;
    data_t read_word;

    // Every request raises exactly one enable, unmapped included
    assign any_en = sel.status_en || sel.dsp_en || sel.pad_en ||
                    sel.flash_ctrl_en || sel.unmapped_en;

    always_comb begin
        read_word = '0;
        if (!sel.write) begin
            if (sel.dsp_en) begin
                read_word = dsp_data;
            end else if (sel.pad_en) begin
                read_word = data_t'(pad_data);
            end else if (sel.flash_ctrl_en) begin
                read_word = flash_data;
            end
            // Status and unmapped reads return zero
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= any_en;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (any_en) begin
            read_data <= read_word;
        end
    end

    // Decoder busy flag keeps a held request from completing twice
    a_ready_pulse: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready |=> !mem_ready);

endmodule

// ==== hw/ics_periph.sv ====
/*
 * Peripheral block top level: status LEDs, address decoder,
 * multiplier, gamepad reader, flash bit-bang and read-back mux
 */

`timescale 1ns/1ps

module ics_periph import ics_periph_pkg::*; #(
    parameter int DSP_WIDTH = 16
) (
    input  logic        vdp_clk,
    input  logic        vdp_reset,

    input  bus_req_t    bus_req,
    input  logic        mem_valid,
    output logic        mem_ready,
    output data_t       read_data,

    output logic [7:0]  led,

    input  logic        btn_u,
    input  logic        btn_1,
    input  logic        btn_2,
    input  logic        btn_3,

    output flash_pins_t flash,
    input  logic [3:0]  flash_out
);

    periph_sel_t sel;
    data_t       dsp_product;
    data_t       flash_ctrl_read;
    logic [1:0]  pad_data;
    logic [7:0]  status;

    periph_decoder decoder (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .bus_req   (bus_req),
        .mem_valid (mem_valid),
        .sel       (sel)
    );

    // Status LEDs, write only
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 8'h00;
        end else if (sel.status_en && sel.write) begin
            status <= sel.wdata[7:0];
        end
    end

    assign led = status;

    dsp_mult #(
        .DSP_WIDTH (DSP_WIDTH)
    ) mult (
        .vdp_clk (vdp_clk),
        .sel     (sel),
        .product (dsp_product)
    );

    pad_reader pad (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .sel       (sel),
        .btn_u     (btn_u),
        .btn_1     (btn_1),
        .btn_2     (btn_2),
        .btn_3     (btn_3),
        .pad_data  (pad_data)
    );

    flash_bitbang flash_ctrl (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .sel       (sel),
        .flash_out (flash_out),
        .flash     (flash),
        .ctrl_read (flash_ctrl_read)
    );

    periph_read_mux read_mux (
        .vdp_clk    (vdp_clk),
        .vdp_reset  (vdp_reset),
        .sel        (sel),
        .dsp_data   (dsp_product),
        .flash_data (flash_ctrl_read),
        .pad_data   (pad_data),
        .mem_ready  (mem_ready),
        .read_data  (read_data)
    );

endmodule

// ==== bench/ics_periph_tb.sv ====
/*
 * Testbench for the peripheral block: clock and reset, host bus tasks,
 * status, multiplier, pad and flash stimulus, bus timing assertion,
 * watchdog and the closing report
 */

`timescale 1ns/1ps

module ics_periph_tb import ics_periph_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int READY_LIMIT  = 8;
    // Roughly 110 bus accesses of 5 cycles each, with a wide margin
    localparam int CYCLE_LIMIT  = 4000;
    localparam logic [31:0] SEED = 32'h567f_e7a2;

    logic        vdp_clk;
    logic        vdp_reset;
    bus_req_t    bus_req;
    logic        mem_valid;
    logic        mem_ready;
    data_t       read_data;
    logic [7:0]  led;
    logic        btn_u;
    logic        btn_1;
    logic        btn_2;
    logic        btn_3;
    flash_pins_t flash;
    logic [3:0]  flash_out;

    int          error_count;
    int          check_count;
    int          cycle_count;
    integer      seed;

    ics_periph #(
        .DSP_WIDTH (16)
    ) dut0 (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .bus_req   (bus_req),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .read_data (read_data),
        .led       (led),
        .btn_u     (btn_u),
        .btn_1     (btn_1),
        .btn_2     (btn_2),
        .btn_3     (btn_3),
        .flash     (flash),
        .flash_out (flash_out)
    );

    initial begin
        vdp_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) vdp_clk = ~vdp_clk;
        end
    end

    // Ready exactly two cycles after valid rises, and at no other time
    a_ready_timing: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready == ($past(mem_valid, 2) && !$past(mem_valid, 3)))
        else begin
            error_count++;
            $display("ERROR mem_ready expected %h got %h",
                     !$sampled(mem_ready), $sampled(mem_ready));
        end

    function automatic addr_t reg_addr(input logic [3:0] region, input logic reg_sel);
        addr_t addr;
        addr = '0;
        addr[REGION_LSB +: REGION_BITS] = region;
        addr[REG_SEL_BIT] = reg_sel;
        return addr;
    endfunction

    function automatic data_t flash_word(input logic active, input logic csn, input logic clk,
                                         input logic [3:0] oe, input logic [3:0] dout);
        data_t word;
        word = '0;
        word[FC_ACTIVE_BIT] = active;
        word[FC_CSN_BIT] = csn;
        word[FC_CLK_BIT] = clk;
        word[FC_OE_LSB +: 4] = oe;
        word[FC_IN_LSB +: 4] = dout;
        return word;
    endfunction

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        check_count++;
        assert (actual === expected)
        else begin
            error_count++;
            $display("ERROR %s expected %h got %h", name, expected, actual);
        end
    endtask

    // One request, held until ready, then valid drops for a cycle
    task automatic bus_access(input addr_t addr, input data_t wdata, input logic [3:0] wstrb,
                              output data_t rdata);
        int waited;
        waited = 0;
        rdata = '0;
        @(posedge vdp_clk);
        bus_req   <= '{addr: addr, wdata: wdata, wstrb: wstrb};
        mem_valid <= 1'b1;
        @(negedge vdp_clk);
        while (!mem_ready && waited < READY_LIMIT) begin
            @(negedge vdp_clk);
            waited++;
        end
        if (mem_ready) begin
            rdata = read_data;
        end else begin
            error_count++;
            $display("Bus error: no mem_ready for the request to address %h", addr);
        end
        @(posedge vdp_clk);
        mem_valid <= 1'b0;
        bus_req   <= '0;
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata);
        data_t unused_rdata;
        bus_access(addr, wdata, 4'hf, unused_rdata);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        bus_access(addr, '0, 4'h0, rdata);
    endtask

    task automatic run_dsp_test(input int pairs);
        logic [31:0]        rnd;
        logic signed [15:0] op_a;
        logic signed [15:0] op_b;
        logic signed [31:0] expected;
        data_t              rdata;
        for (int i = 0; i < pairs; i++) begin
            rnd = $random(seed);
            op_a = rnd[15:0];
            op_b = rnd[31:16];
            expected = op_a * op_b;
            bus_write(reg_addr(DSP, 1'b0), {16'h0000, op_a});
            bus_write(reg_addr(DSP, 1'b1), {16'h0000, op_b});
            bus_read(reg_addr(DSP, 1'b0), rdata);
            check_value("dsp product", expected, rdata);
        end
    endtask

    task automatic write_pad_control(input logic latch, input logic clk);
        data_t word;
        word = '0;
        word[PAD_LATCH_BIT] = latch;
        word[PAD_CLK_BIT] = clk;
        bus_write(reg_addr(PAD, 1'b0), word);
    endtask

    task automatic pulse_pad_clock();
        write_pad_control(1'b0, 1'b1);
        write_pad_control(1'b0, 1'b0);
    endtask

    task automatic run_pad_test(input logic b_u, input logic b_1, input logic b_2,
                                input logic b_3);
        data_t rdata;
        @(posedge vdp_clk);
        btn_u <= b_u;
        btn_1 <= b_1;
        btn_2 <= b_2;
        btn_3 <= b_3;
        write_pad_control(1'b1, 1'b0);
        write_pad_control(1'b0, 1'b0);
        bus_read(reg_addr(PAD, 1'b0), rdata);
        check_value("pad_data[0] after latch", data_t'(b_2), data_t'(rdata[0]));
        check_value("pad_data[1]", data_t'(b_u), data_t'(rdata[1]));
        repeat (6) begin
            pulse_pad_clock();
        end
        bus_read(reg_addr(PAD, 1'b0), rdata);
        check_value("pad_data[0] after 6 clocks", data_t'(b_3), data_t'(rdata[0]));
        pulse_pad_clock();
        bus_read(reg_addr(PAD, 1'b0), rdata);
        check_value("pad_data[0] after 7 clocks", data_t'(b_1), data_t'(rdata[0]));
        check_value("pad_data[1]", data_t'(b_u), data_t'(rdata[1]));
    endtask

    task automatic run_flash_test(input logic csn, input logic clk, input logic [3:0] oe,
                                  input logic [3:0] dout);
        flash_pins_t expected;
        bus_write(reg_addr(FLASH_CTRL, 1'b0), flash_word(1'b1, csn, clk, oe, dout));
        // Both DDR phases carry the clock field
        expected.clk_ddr = {clk, clk};
        expected.csn = csn;
        expected.dout = dout;
        expected.oe = oe;
        check_value("flash", data_t'(expected), data_t'(flash));
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge vdp_clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("sim failed");
        $finish;
    end

    initial begin : stimulus
        data_t rdata;
        error_count = 0;
        check_count = 0;
        seed = SEED;
        vdp_reset <= 1'b1;
        mem_valid <= 1'b0;
        bus_req   <= '0;
        btn_u     <= 1'b0;
        btn_1     <= 1'b0;
        btn_2     <= 1'b0;
        btn_3     <= 1'b0;
        flash_out <= 4'h0;
        repeat (RESET_CYCLES) @(posedge vdp_clk);
        vdp_reset <= 1'b0;
        @(negedge vdp_clk);
        check_value("mem_ready", 32'h0, data_t'(mem_ready));
        check_value("led", 32'h0, data_t'(led));
        check_value("flash.oe", 32'h0, data_t'(flash.oe));
        check_value("flash.csn", 32'h1, data_t'(flash.csn));
        check_value("flash.clk_ddr", 32'h0, data_t'(flash.clk_ddr));

        // Status register and unmapped space
        bus_write(reg_addr(STATUS, 1'b0), 32'h1234_56a5);
        check_value("led", 32'ha5, data_t'(led));
        bus_write(reg_addr(STATUS, 1'b1), 32'hffff_ff3c);
        check_value("led", 32'h3c, data_t'(led));
        bus_read(reg_addr(STATUS, 1'b0), rdata);
        check_value("status read_data", 32'h0, rdata);
        bus_write(reg_addr(4'h7, 1'b0), 32'hdead_beef);
        check_value("led", 32'h3c, data_t'(led));
        bus_read(reg_addr(4'h7, 1'b0), rdata);
        check_value("unmapped read_data", 32'h0, rdata);
        bus_read(reg_addr(4'hf, 1'b1), rdata);
        check_value("unmapped read_data", 32'h0, rdata);

        run_dsp_test(20);

        run_pad_test(1'b1, 1'b0, 1'b1, 1'b1);
        run_pad_test(1'b0, 1'b1, 1'b0, 1'b0);

        run_flash_test(1'b0, 1'b1, 4'ha, 4'h5);
        run_flash_test(1'b1, 1'b0, 4'h3, 4'hc);
        // Active clear with every other field set still idles the pins
        bus_write(reg_addr(FLASH_CTRL, 1'b0), flash_word(1'b0, 1'b0, 1'b1, 4'hf, 4'hf));
        check_value("flash.clk_ddr", 32'h0, data_t'(flash.clk_ddr));
        check_value("flash.csn", 32'h1, data_t'(flash.csn));
        check_value("flash.oe", 32'h0, data_t'(flash.oe));
        @(posedge vdp_clk);
        flash_out <= 4'hc;
        bus_read(reg_addr(FLASH_CTRL, 1'b0), rdata);
        check_value("flash read_data", 32'hc, rdata);
        @(posedge vdp_clk);
        flash_out <= 4'h3;
        bus_read(reg_addr(FLASH_CTRL, 1'b0), rdata);
        check_value("flash read_data", 32'h3, rdata);

        repeat (4) @(posedge vdp_clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== ics_periph.f ====
hw/ics_periph_pkg.sv
hw/periph_decoder.sv
hw/dsp_mult.sv
hw/pad_reader.sv
hw/flash_bitbang.sv
hw/periph_read_mux.sv
hw/ics_periph.sv
bench/ics_periph_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the peripheral block testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module ics_periph_tb \
    --Mdir "$BUILD_DIR" \
    -f ics_periph.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vics_periph_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
